// File: sram_settings.svh
`ifndef SRAM_SETTINGS_SVH
`define SRAM_SETTINGS_SVH

// ===========================================================================
// Bus widths
// ===========================================================================
`define AXIL_ADDR_WIDTH 16

// The strobe width and the channel structs follow from this width.
`define AXIL_DATA_WIDTH 64

// ===========================================================================
// SRAM size and address map
// ===========================================================================
`define SRAM_SIZE_KB 4

`define SRAM_BASE 16'h0000
`define REGS_BASE 16'h8000
`define REGS_SPAN 16'h0020

`endif

// File: axil_pkg.sv
`include "sram_settings.svh"

package axil_pkg;

    // ========================================================================
    // AXI4-Lite channel payloads
    // ========================================================================
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axil_resp_e;

    // Shared by the AW and AR channels.
    typedef struct packed {
        logic [`AXIL_ADDR_WIDTH-1:0] addr;
    } axil_addr_t;

    typedef struct packed {
        logic [`AXIL_DATA_WIDTH-1:0]   data;
        logic [`AXIL_DATA_WIDTH/8-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [`AXIL_DATA_WIDTH-1:0] data;
        axil_resp_e                  resp;
    } axil_r_t;

    typedef struct packed {
        axil_resp_e resp;
    } axil_b_t;

    // Word offsets inside the control/status register window.
    typedef enum logic [4:0] {
        REG_CTRL    = 5'h00,
        REG_WR_ERRS = 5'h08,
        REG_RD_ERRS = 5'h10
    } regs_offset_e;

endpackage

// File: axil_decoder.sv
`timescale 1ns/1ps
`include "sram_settings.svh"

module axil_decoder
    import axil_pkg::*;
(
    input  logic       bus,
    input  logic       rst,
    input  axil_addr_t m_aw,
    input  logic       m_awvalid,
    output logic       m_awready,
    input  axil_w_t    m_w,
    input  logic       m_wvalid,
    output logic       m_wready,
    output axil_b_t    m_b,
    output logic       m_bvalid,
    input  logic       m_bready,
    input  axil_addr_t m_ar,
    input  logic       m_arvalid,
    output logic       m_arready,
    output axil_r_t    m_r,
    output logic       m_rvalid,
    input  logic       m_rready,
    output axil_addr_t mem_aw,
    output logic       mem_awvalid,
    input  logic       mem_awready,
    output axil_w_t    mem_w,
    output logic       mem_wvalid,
    input  logic       mem_wready,
    input  axil_b_t    mem_b,
    input  logic       mem_bvalid,
    output logic       mem_bready,
    output axil_addr_t mem_ar,
    output logic       mem_arvalid,
    input  logic       mem_arready,
    input  axil_r_t    mem_r,
    input  logic       mem_rvalid,
    output logic       mem_rready,
    output axil_addr_t reg_aw,
    output logic       reg_awvalid,
    input  logic       reg_awready,
    output axil_w_t    reg_w,
    output logic       reg_wvalid,
    input  logic       reg_wready,
    input  axil_b_t    reg_b,
    input  logic       reg_bvalid,
    output logic       reg_bready,
    output axil_addr_t reg_ar,
    output logic       reg_arvalid,
    input  logic       reg_arready,
    input  axil_r_t    reg_r,
    input  logic       reg_rvalid,
    output logic       reg_rready
);

    typedef enum logic [1:0] {TGT_IDLE, TGT_MEM, TGT_REG, TGT_DECERR} tgt_e;

    localparam int unsigned MEM_END = `SRAM_BASE + `SRAM_SIZE_KB * 1024;
    localparam int unsigned REG_END = `REGS_BASE + `REGS_SPAN;

    function automatic tgt_e decode(input logic [`AXIL_ADDR_WIDTH-1:0] a);
        if (a >= `SRAM_BASE && a < MEM_END) return TGT_MEM;
        if (a >= `REGS_BASE && a < REG_END) return TGT_REG;
        return TGT_DECERR;
    endfunction

    tgt_e ar_sel;
    tgt_e aw_sel;
    tgt_e rd_tgt;
    tgt_e wr_tgt;
    logic w_done;

    assign ar_sel = decode(m_ar.addr);
    assign aw_sel = decode(m_aw.addr);

    // Slaves see the offset within their own window.
    assign mem_ar.addr = m_ar.addr - `SRAM_BASE;
    assign reg_ar.addr = m_ar.addr - `REGS_BASE;
    assign mem_aw.addr = m_aw.addr - `SRAM_BASE;
    assign reg_aw.addr = m_aw.addr - `REGS_BASE;
    assign mem_w = m_w;
    assign reg_w = m_w;

    // ========================================================================
    // Read channels
    // ========================================================================
    assign mem_arvalid = m_arvalid && rd_tgt == TGT_IDLE && ar_sel == TGT_MEM;
    assign reg_arvalid = m_arvalid && rd_tgt == TGT_IDLE && ar_sel == TGT_REG;
    assign mem_rready  = m_rready && rd_tgt == TGT_MEM;
    assign reg_rready  = m_rready && rd_tgt == TGT_REG;

    always_comb begin
        case (ar_sel)
            TGT_MEM: m_arready = mem_arready;
            TGT_REG: m_arready = reg_arready;
            default: m_arready = 1'b1;
        endcase
        if (rd_tgt != TGT_IDLE) m_arready = 1'b0;
    end

    // Unmapped reads are answered here, one cycle after the address.
    always_comb begin
        m_rvalid = 1'b0;
        m_r      = '{data: '0, resp: DECERR};
        case (rd_tgt)
            TGT_MEM: begin
                m_rvalid = mem_rvalid;
                m_r      = mem_r;
            end
            TGT_REG: begin
                m_rvalid = reg_rvalid;
                m_r      = reg_r;
            end
            TGT_DECERR: m_rvalid = 1'b1;
            default: m_rvalid = 1'b0;
        endcase
    end

    // ========================================================================
    // Write channels
    // ========================================================================
    assign mem_awvalid = m_awvalid && wr_tgt == TGT_IDLE && aw_sel == TGT_MEM;
    assign reg_awvalid = m_awvalid && wr_tgt == TGT_IDLE && aw_sel == TGT_REG;
    assign mem_wvalid  = m_wvalid && !w_done && wr_tgt == TGT_MEM;
    assign reg_wvalid  = m_wvalid && !w_done && wr_tgt == TGT_REG;
    assign mem_bready  = m_bready && wr_tgt == TGT_MEM;
    assign reg_bready  = m_bready && wr_tgt == TGT_REG;

    always_comb begin
        case (aw_sel)
            TGT_MEM: m_awready = mem_awready;
            TGT_REG: m_awready = reg_awready;
            default: m_awready = 1'b1;
        endcase
        if (wr_tgt != TGT_IDLE) m_awready = 1'b0;
    end

    // W is only taken once the target is known, and only one beat per write.
    always_comb begin
        case (wr_tgt)
            TGT_MEM:    m_wready = mem_wready;
            TGT_REG:    m_wready = reg_wready;
            TGT_DECERR: m_wready = 1'b1;
            default:    m_wready = 1'b0;
        endcase
        if (w_done) m_wready = 1'b0;
    end

    always_comb begin
        m_bvalid = 1'b0;
        m_b      = '{resp: DECERR};
        case (wr_tgt)
            TGT_MEM: begin
                m_bvalid = mem_bvalid;
                m_b      = mem_b;
            end
            TGT_REG: begin
                m_bvalid = reg_bvalid;
                m_b      = reg_b;
            end
            TGT_DECERR: m_bvalid = w_done;
            default: m_bvalid = 1'b0;
        endcase
    end

    always_ff @(posedge bus) begin
        if (rst) begin
            rd_tgt <= TGT_IDLE;
            wr_tgt <= TGT_IDLE;
            w_done <= 1'b0;
        end else begin
            if (m_arvalid && m_arready) begin
                rd_tgt <= ar_sel;
            end else if (m_rvalid && m_rready) begin
                rd_tgt <= TGT_IDLE;
            end
            if (m_awvalid && m_awready) begin
                wr_tgt <= aw_sel;
            end else if (m_bvalid && m_bready) begin
                wr_tgt <= TGT_IDLE;
                w_done <= 1'b0;
            end
            if (m_wvalid && m_wready) w_done <= 1'b1;
        end
    end

endmodule

// File: axil_sram.sv
`timescale 1ns/1ps
`include "sram_settings.svh"

module axil_sram
    import axil_pkg::*;
(
    input  logic       bus,
    input  logic       rst,
    input  axil_addr_t aw,
    input  logic       awvalid,
    output logic       awready,
    input  axil_w_t    w,
    input  logic       wvalid,
    output logic       wready,
    output axil_b_t    b,
    output logic       bvalid,
    input  logic       bready,
    input  axil_addr_t ar,
    input  logic       arvalid,
    output logic       arready,
    output axil_r_t    r,
    output logic       rvalid,
    input  logic       rready,
    input  logic       write_protect,
    output logic       wr_err,
    output logic       rd_err
);

    localparam int          AW    = `AXIL_ADDR_WIDTH;
    localparam int          DW    = `AXIL_DATA_WIDTH;
    localparam int          NB    = DW / 8;
    localparam int          LSB   = $clog2(NB);
    localparam int unsigned BYTES = `SRAM_SIZE_KB * 1024;
    localparam int          WORDS = BYTES / NB;
    localparam int          IW    = $clog2(WORDS);

    logic [DW-1:0] mem [WORDS];

    logic          rd_pend;
    logic [AW-1:0] rd_buf;
    logic [AW-1:0] raddr;
    logic [IW-1:0] ridx;
    logic          rd_bad;
    logic          ar_fire;
    logic          rd_load;
    logic [DW-1:0] rd_word;

    logic          aw_pend;
    logic          w_pend;
    logic [AW-1:0] wa_buf;
    axil_w_t       wd_buf;
    logic [AW-1:0] waddr;
    axil_w_t       wdat;
    logic [IW-1:0] widx;
    logic          wr_bad;
    logic          aw_fire;
    logic          w_fire;
    logic          wr_go;
    logic          wr_en;

    // ========================================================================
    // Read path
    // ========================================================================
    assign arready = !rd_pend;
    assign ar_fire = arvalid && arready;
    assign raddr   = rd_pend ? rd_buf : ar.addr;
    assign ridx    = raddr[LSB +: IW];
    assign rd_bad  = (|raddr[LSB-1:0]) || (raddr >= BYTES);

    // A new read is loaded whenever the R register is free or being drained.
    assign rd_load = (rd_pend || ar_fire) && (!rvalid || rready);

    // Bytes written in this same cycle to the word being read win over the array.
    always_comb begin
        rd_word = mem[ridx];
        for (int i = 0; i < NB; i++) begin
            if (wr_en && widx == ridx && wdat.strb[i]) begin
                rd_word[i*8 +: 8] = wdat.data[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge bus) begin
        if (rst) begin
            rd_pend <= 1'b0;
            rvalid  <= 1'b0;
            rd_err  <= 1'b0;
        end else begin
            rd_err <= rd_load && rd_bad;
            if (rd_load) begin
                rvalid  <= 1'b1;
                rd_pend <= 1'b0;
            end else if (ar_fire) begin
                rd_pend <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge bus) begin
        if (ar_fire && !rd_load) rd_buf <= ar.addr;
        if (rd_load) begin
            r.data <= rd_bad ? '0 : rd_word;
            r.resp <= rd_bad ? SLVERR : OKAY;
        end
    end

    // ========================================================================
    // Write path
    // ========================================================================
    assign awready = !aw_pend;
    assign wready  = !w_pend;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign waddr   = aw_pend ? wa_buf : aw.addr;
    assign wdat    = w_pend ? wd_buf : w;
    assign widx    = waddr[LSB +: IW];
    assign wr_bad  = write_protect || (|waddr[LSB-1:0]) || (waddr >= BYTES);

    // Address and data may arrive in either order; the write completes once
    // both are present and the B register can take the response.
    assign wr_go = (aw_pend || aw_fire) && (w_pend || w_fire) && (!bvalid || bready);
    assign wr_en = wr_go && !wr_bad;

    always_ff @(posedge bus) begin
        if (rst) begin
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
            bvalid  <= 1'b0;
            wr_err  <= 1'b0;
        end else begin
            wr_err <= wr_go && wr_bad;
            if (wr_go) begin
                aw_pend <= 1'b0;
                w_pend  <= 1'b0;
                bvalid  <= 1'b1;
            end else begin
                if (aw_fire) aw_pend <= 1'b1;
                if (w_fire) w_pend <= 1'b1;
                if (bready) bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge bus) begin
        if (aw_fire) wa_buf <= aw.addr;
        if (w_fire) wd_buf <= w;
        if (wr_go) b.resp <= wr_bad ? SLVERR : OKAY;
    end

    always_ff @(posedge bus) begin
        for (int i = 0; i < NB; i++) begin
            if (wr_en && wdat.strb[i]) begin
                mem[widx][i*8 +: 8] <= wdat.data[i*8 +: 8];
            end
        end
    end

endmodule

// File: axil_sram_regs.sv
`timescale 1ns/1ps
`include "sram_settings.svh"

module axil_sram_regs
    import axil_pkg::*;
(
    input  logic       bus,
    input  logic       rst,
    input  axil_addr_t aw,
    input  logic       awvalid,
    output logic       awready,
    input  axil_w_t    w,
    input  logic       wvalid,
    output logic       wready,
    output axil_b_t    b,
    output logic       bvalid,
    input  logic       bready,
    input  axil_addr_t ar,
    input  logic       arvalid,
    output logic       arready,
    output axil_r_t    r,
    output logic       rvalid,
    input  logic       rready,
    input  logic       wr_err,
    input  logic       rd_err,
    output logic       write_protect
);

    localparam int AW = `AXIL_ADDR_WIDTH;
    localparam int DW = `AXIL_DATA_WIDTH;
    localparam int CW = 32;

    logic          aw_got;
    logic          w_got;
    logic [AW-1:0] wa_buf;
    axil_w_t       wd_buf;
    logic [AW-1:0] waddr;
    axil_w_t       wdat;
    logic          wr_go;
    logic [CW-1:0] wr_errs;
    logic [CW-1:0] rd_errs;

    function automatic logic offset_ok(input logic [AW-1:0] a);
        logic ok;
        ok = (a < `REGS_SPAN);
        case (a[4:0])
            REG_CTRL, REG_WR_ERRS, REG_RD_ERRS: offset_ok = ok;
            default: offset_ok = 1'b0;
        endcase
    endfunction

    // ========================================================================
    // Read side, one transaction at a time
    // ========================================================================
    assign arready = !rvalid;

    always_ff @(posedge bus) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge bus) begin
        if (arvalid && arready) begin
            r.resp <= offset_ok(ar.addr) ? OKAY : SLVERR;
            case (ar.addr[4:0])
                REG_CTRL:    r.data <= DW'(write_protect);
                REG_WR_ERRS: r.data <= DW'(wr_errs);
                REG_RD_ERRS: r.data <= DW'(rd_errs);
                default:     r.data <= '0;
            endcase
        end
    end

    // ========================================================================
    // Write side and counters
    // ========================================================================
    assign awready = !aw_got && !bvalid;
    assign wready  = !w_got && !bvalid;
    assign waddr   = aw_got ? wa_buf : aw.addr;
    assign wdat    = w_got ? wd_buf : w;
    assign wr_go   = (aw_got || (awvalid && awready)) && (w_got || (wvalid && wready));

    always_ff @(posedge bus) begin
        if (rst) begin
            aw_got        <= 1'b0;
            w_got         <= 1'b0;
            bvalid        <= 1'b0;
            write_protect <= 1'b0;
            wr_errs       <= '0;
            rd_errs       <= '0;
        end else begin
            if (wr_go) begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
            end else begin
                if (awvalid && awready) aw_got <= 1'b1;
                if (wvalid && wready) w_got <= 1'b1;
                if (bready) bvalid <= 1'b0;
            end
            // Only the control word is writable; the counters ignore writes.
            if (wr_go && offset_ok(waddr) && waddr[4:0] == REG_CTRL && wdat.strb[0]) begin
                write_protect <= wdat.data[0];
            end
            if (wr_err && wr_errs != '1) wr_errs <= wr_errs + 1'b1;
            if (rd_err && rd_errs != '1) rd_errs <= rd_errs + 1'b1;
        end
    end

    always_ff @(posedge bus) begin
        if (awvalid && awready) wa_buf <= aw.addr;
        if (wvalid && wready) wd_buf <= w;
        if (wr_go) b.resp <= offset_ok(waddr) ? OKAY : SLVERR;
    end

endmodule

// File: sram_subsystem.sv
`timescale 1ns/1ps

module sram_subsystem
    import axil_pkg::*;
(
    input  logic       bus,
    input  logic       rst,
    input  axil_addr_t aw,
    input  logic       awvalid,
    output logic       awready,
    input  axil_w_t    w,
    input  logic       wvalid,
    output logic       wready,
    output axil_b_t    b,
    output logic       bvalid,
    input  logic       bready,
    input  axil_addr_t ar,
    input  logic       arvalid,
    output logic       arready,
    output axil_r_t    r,
    output logic       rvalid,
    input  logic       rready
);

    axil_addr_t mem_aw, mem_ar, reg_aw, reg_ar;
    axil_w_t    mem_w, reg_w;
    axil_b_t    mem_b, reg_b;
    axil_r_t    mem_r, reg_r;
    logic       mem_awvalid, mem_awready, mem_wvalid, mem_wready, mem_bvalid, mem_bready;
    logic       mem_arvalid, mem_arready, mem_rvalid, mem_rready;
    logic       reg_awvalid, reg_awready, reg_wvalid, reg_wready, reg_bvalid, reg_bready;
    logic       reg_arvalid, reg_arready, reg_rvalid, reg_rready;
    logic       write_protect;
    logic       wr_err;
    logic       rd_err;

    // Slave-side ports share their names with the local nets.
    axil_decoder decoder0 (
        .*,
        .m_aw(aw), .m_awvalid(awvalid), .m_awready(awready),
        .m_w(w), .m_wvalid(wvalid), .m_wready(wready),
        .m_b(b), .m_bvalid(bvalid), .m_bready(bready),
        .m_ar(ar), .m_arvalid(arvalid), .m_arready(arready),
        .m_r(r), .m_rvalid(rvalid), .m_rready(rready)
    );

    axil_sram sram0 (
        .bus(bus), .rst(rst),
        .aw(mem_aw), .awvalid(mem_awvalid), .awready(mem_awready),
        .w(mem_w), .wvalid(mem_wvalid), .wready(mem_wready),
        .b(mem_b), .bvalid(mem_bvalid), .bready(mem_bready),
        .ar(mem_ar), .arvalid(mem_arvalid), .arready(mem_arready),
        .r(mem_r), .rvalid(mem_rvalid), .rready(mem_rready),
        .write_protect(write_protect), .wr_err(wr_err), .rd_err(rd_err)
    );

    axil_sram_regs regs0 (
        .bus(bus), .rst(rst),
        .aw(reg_aw), .awvalid(reg_awvalid), .awready(reg_awready),
        .w(reg_w), .wvalid(reg_wvalid), .wready(reg_wready),
        .b(reg_b), .bvalid(reg_bvalid), .bready(reg_bready),
        .ar(reg_ar), .arvalid(reg_arvalid), .arready(reg_arready),
        .r(reg_r), .rvalid(reg_rvalid), .rready(reg_rready),
        .wr_err(wr_err), .rd_err(rd_err), .write_protect(write_protect)
    );

endmodule

// File: tb_sram_subsystem.sv
`timescale 1ns/1ps
`include "sram_settings.svh"

module tb_sram_subsystem
    import axil_pkg::*;
;

    typedef struct {
        logic        is_write;
        logic [15:0] addr;
        logic [63:0] data;
        logic [7:0]  strb;
        axil_resp_e  resp;
        logic        use_model;
    } row_t;

    logic       bus;
    logic       rst;
    axil_addr_t aw;
    logic       awvalid;
    logic       awready;
    axil_w_t    w;
    logic       wvalid;
    logic       wready;
    axil_b_t    b;
    logic       bvalid;
    logic       bready;
    axil_addr_t ar;
    logic       arvalid;
    logic       arready;
    axil_r_t    r;
    logic       rvalid;
    logic       rready;

    row_t        rows[$];
    logic [63:0] model_mem [int];
    logic        wp_shadow;
    int          wr_errs;
    int          rd_errs;
    int          errors;
    int          checks;
    int          cycles;
    int          limit;
    integer      seed = 32'h6e67_441c;

    logic        r_held;
    axil_r_t     r_last;
    logic        b_held;
    axil_b_t     b_last;

    sram_subsystem dut0 (.*);

    always #5 bus = ~bus;

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: got %h, expected %h (t=%0t)", name, actual, expected, $time);
        end
    endtask

    task automatic add_row(input logic is_write, input logic [15:0] addr,
                           input logic [63:0] data, input logic [7:0] strb,
                           input axil_resp_e resp, input logic use_model);
        row_t row;
        row = '{is_write, addr, data, strb, resp, use_model};
        rows.push_back(row);
    endtask

    function automatic logic in_sram(input logic [15:0] addr);
        return addr >= `SRAM_BASE && addr < `SRAM_BASE + `SRAM_SIZE_KB * 1024;
    endfunction

    // An SRAM write followed by a read of the same word runs as one overlapped pair.
    function automatic logic pairs_with_read(input int idx);
        if (idx + 1 >= rows.size()) return 1'b0;
        return rows[idx].is_write && !rows[idx + 1].is_write
            && rows[idx + 1].addr == rows[idx].addr && in_sram(rows[idx].addr);
    endfunction

    function automatic logic [63:0] model_read(input logic [15:0] addr);
        if (addr == `REGS_BASE + 16'(REG_CTRL)) return {63'b0, wp_shadow};
        if (addr == `REGS_BASE + 16'(REG_WR_ERRS)) return 64'(wr_errs);
        if (addr == `REGS_BASE + 16'(REG_RD_ERRS)) return 64'(rd_errs);
        if (model_mem.exists(int'(addr >> 3))) return model_mem[int'(addr >> 3)];
        return 'x;
    endfunction

    // Merge the strobed bytes into the reference word.
    task automatic model_write(input logic [15:0] addr, input logic [63:0] data,
                               input logic [7:0] strb);
        logic [63:0] word;
        int          idx;
        idx = int'(addr >> 3);
        word = model_mem.exists(idx) ? model_mem[idx] : 'x;
        for (int k = 0; k < 8; k++) begin
            if (strb[k]) word[k*8 +: 8] = data[k*8 +: 8];
        end
        model_mem[idx] = word;
    endtask

    task automatic score_write(input row_t row, input axil_resp_e resp);
        check("b.resp", resp, row.resp);
        if (row.resp == OKAY && in_sram(row.addr)) begin
            model_write(row.addr, row.data, row.strb);
        end
        if (row.resp == OKAY && row.addr == `REGS_BASE && row.strb[0]) begin
            wp_shadow = row.data[0];
        end
        if (row.resp == SLVERR && in_sram(row.addr)) wr_errs++;
    endtask

    task automatic score_read(input row_t row, input logic [63:0] rdata,
                              input axil_resp_e resp);
        check("r.resp", resp, row.resp);
        if (row.resp == OKAY) begin
            check("r.data", rdata, row.use_model ? model_read(row.addr) : row.data);
        end
        if (row.resp == SLVERR && in_sram(row.addr)) rd_errs++;
    endtask

    // ========================================================================
    // Bus transactions start and end on a falling edge
    // ========================================================================
    task automatic write_txn(input logic [15:0] addr, input logic [63:0] data,
                             input logic [7:0] strb, output axil_resp_e resp);
        logic aw_ok;
        logic w_ok;
        int   delay;
        aw.addr = addr;
        w.data  = data;
        w.strb  = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        aw_ok   = 1'b0;
        w_ok    = 1'b0;
        while (!(aw_ok && w_ok)) begin
            @(posedge bus);
            if (awvalid && awready) aw_ok = 1'b1;
            if (wvalid && wready) w_ok = 1'b1;
            @(negedge bus);
            if (aw_ok) awvalid = 1'b0;
            if (w_ok) wvalid = 1'b0;
        end
        delay = $random(seed) & 3;
        repeat (delay) @(negedge bus);
        bready = 1'b1;
        do @(posedge bus); while (!bvalid);
        resp = b.resp;
        @(negedge bus);
        bready = 1'b0;
    endtask

    task automatic read_txn(input logic [15:0] addr, output logic [63:0] data,
                            output axil_resp_e resp);
        int delay;
        ar.addr = addr;
        arvalid = 1'b1;
        do @(posedge bus); while (!arready);
        @(negedge bus);
        arvalid = 1'b0;
        delay = $random(seed) & 3;
        repeat (delay) @(negedge bus);
        rready = 1'b1;
        do @(posedge bus); while (!rvalid);
        data = r.data;
        resp = r.resp;
        @(negedge bus);
        rready = 1'b0;
    endtask

    task automatic build_table();
        add_row(1, 16'h0100, 64'h1122_3344_5566_7788, 8'hff, OKAY, 1);
        add_row(0, 16'h0100, 64'h0, 8'h00, OKAY, 1);
        add_row(1, 16'h0100, 64'haabb_ccdd_eeff_0011, 8'h0f, OKAY, 1);
        add_row(0, 16'h0100, 64'h0, 8'h00, OKAY, 1);
        add_row(1, 16'h0208, 64'h0123_4567_89ab_cdef, 8'hff, OKAY, 1);
        add_row(1, 16'h0208, 64'hffee_ddcc_bbaa_9988, 8'ha5, OKAY, 1);
        add_row(0, 16'h0208, 64'h0, 8'h00, OKAY, 1);
        // Misaligned accesses.
        add_row(0, 16'h0104, 64'h0, 8'h00, SLVERR, 1);
        add_row(1, 16'h0104, 64'hdead_beef_dead_beef, 8'hff, SLVERR, 1);
        add_row(0, 16'h0100, 64'h0, 8'h00, OKAY, 1);
        // Write protect on, then off again.
        add_row(1, 16'h8000, 64'h1, 8'h01, OKAY, 1);
        add_row(0, 16'h8000, 64'h1, 8'h00, OKAY, 0);
        add_row(1, 16'h0100, 64'h5555_5555_5555_5555, 8'hff, SLVERR, 1);
        add_row(0, 16'h0100, 64'h0, 8'h00, OKAY, 1);
        add_row(1, 16'h8000, 64'h0, 8'h01, OKAY, 1);
        add_row(0, 16'h8000, 64'h0, 8'h00, OKAY, 1);
        add_row(1, 16'h0100, 64'h0f0e_0d0c_0b0a_0908, 8'hff, OKAY, 1);
        add_row(0, 16'h0100, 64'h0, 8'h00, OKAY, 1);
        add_row(1, 16'h0ff8, 64'h8765_4321_0fed_cba9, 8'hff, OKAY, 1);
        add_row(0, 16'h0ff8, 64'h0, 8'h00, OKAY, 1);
        // Register errors must not add to the error counters.
        add_row(0, 16'h8008, 64'h0, 8'h00, OKAY, 1);
        add_row(0, 16'h8010, 64'h0, 8'h00, OKAY, 1);
        add_row(1, 16'h8018, 64'h1, 8'hff, SLVERR, 1);
        add_row(1, 16'h8008, 64'h77, 8'hff, OKAY, 1);
        add_row(0, 16'h8008, 64'h0, 8'h00, OKAY, 1);
        // Unmapped addresses.
        add_row(0, 16'h4000, 64'h0, 8'h00, DECERR, 1);
        add_row(1, 16'h4000, 64'h1234, 8'hff, DECERR, 1);
        add_row(0, 16'h1000, 64'h0, 8'h00, DECERR, 1);
    endtask

    // ========================================================================
    // Payload stability while the master stalls
    // ========================================================================
    always @(posedge bus) begin
        if (rst) begin
            r_held <= 1'b0;
            b_held <= 1'b0;
        end else begin
            if (r_held) begin
                check("rvalid held", rvalid, 1'b1);
                check("r.data held", r.data, r_last.data);
                check("r.resp held", r.resp, r_last.resp);
            end
            if (b_held) begin
                check("bvalid held", bvalid, 1'b1);
                check("b.resp held", b.resp, b_last.resp);
            end
            r_held <= rvalid && !rready;
            r_last <= r;
            b_held <= bvalid && !bready;
            b_last <= b;
        end
    end

    always @(posedge bus) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("Run timed out after %0d cycles without finishing the table", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        row_t        row;
        logic [63:0] rdata;
        axil_resp_e  resp;
        axil_resp_e  rresp;
        int          i;
        bus       = 1'b0;
        rst       = 1'b1;
        aw        = '0;
        awvalid   = 1'b0;
        w         = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        ar        = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        wp_shadow = 1'b0;
        wr_errs   = 0;
        rd_errs   = 0;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        build_table();
        limit = rows.size() * 20 + 100;
        repeat (2) @(posedge bus);
        @(negedge bus);
        rst = 1'b0;
        check("rvalid", rvalid, 1'b0);
        check("bvalid", bvalid, 1'b0);
        i = 0;
        while (i < rows.size()) begin
            row = rows[i];
            if (pairs_with_read(i)) begin
                // The read address lands on the edge that takes the write data.
                fork
                    write_txn(row.addr, row.data, row.strb, resp);
                    begin
                        @(negedge bus);
                        read_txn(row.addr, rdata, rresp);
                    end
                join
                score_write(row, resp);
                score_read(rows[i + 1], rdata, rresp);
                i += 2;
            end else if (row.is_write) begin
                write_txn(row.addr, row.data, row.strb, resp);
                score_write(row, resp);
                i++;
            end else begin
                read_txn(row.addr, rdata, resp);
                score_read(row, rdata, resp);
                i++;
            end
        end
        repeat (2) @(negedge bus);
        $display("Finished %0d rows: %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
axil_pkg.sv
axil_decoder.sv
axil_sram.sv
axil_sram_regs.sv
sram_subsystem.sv
tb_sram_subsystem.sv

// File: Bender.yml
package:
  name: sram_subsystem

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - axil_pkg.sv
      - axil_decoder.sv
      - axil_sram.sv
      - axil_sram_regs.sv
      - sram_subsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_sram_subsystem.sv
